// File: eth_fcs_gen.sv
module eth_fcs_gen (
  input  logic        gmii_tx_clk,
  input  logic        sys_rst,
  input  logic        crc_init,
  input  logic        crc_en,
  input  logic [7:0]  data,
  output logic [31:0] fcs
);

  // 04C11DB7 in reflected form
  localparam logic [31:0] poly_rev = 32'hedb88320;

  logic [31:0] crc_q;
  logic [31:0] crc_next;
  logic [31:0] crc_view;

  // lsb first, matching the bit order on the wire
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ poly_rev;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  assign crc_next = crc_byte(crc_q, data);

  // look ahead over the byte on the bus this cycle,
  // so the first fcs byte can be taken right after the last payload byte
  always_comb begin
    if (crc_init) begin
      crc_view = '1;
    end else if (crc_en) begin
      crc_view = crc_next;
    end else begin
      crc_view = crc_q;
    end
  end

  // low byte of the reflected register leaves first, so it sits in fcs[31:24]
  assign fcs = ~{crc_view[7:0], crc_view[15:8], crc_view[23:16], crc_view[31:24]};

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst || crc_init) begin
      crc_q <= '1;
    end else if (crc_en) begin
      crc_q <= crc_next;
    end
  end

endmodule

// File: frame_sender.sv
module frame_sender #(
  parameter int addr_w     = 14,
  parameter int ifg_cycles = 12
) (
  input  logic                                                   gmii_tx_clk,
  input  logic                                                   sys_rst,
  input  logic [addr_w-1:0]                                      commit_ptr,
  input  logic [15:0]                                            rd_q,
  output logic [addr_w-1:0]                                      rd_addr,
  input  logic [63:0]                                            global_counter,
  input  logic [tsx_pkg::n_local_times-1:0][tsx_pkg::time_w-1:0] local_times,
  output logic [tsx_pkg::n_local_times-1:0]                      local_time_req,
  input  logic [31:0]                                            fcs,
  output logic                                                   crc_init,
  output logic                                                   crc_en,
  output tsx_pkg::gmii_tx_t                                      gmii,
  input  logic [7:0]                                             dipsw,
  output logic [7:0]                                             led
);

  localparam int hdr_cnt_w = $clog2(tsx_pkg::hdr_words + 1);
  localparam int ifg_w     = $clog2(ifg_cycles + 1);
  localparam int hdr_bits  = 16 * tsx_pkg::hdr_words;
  localparam logic [16:0] sfd_idx = 17'(tsx_pkg::preamble_len - 1);
  localparam logic [tsx_pkg::n_local_times-1:0] req_one = 1;

  tsx_pkg::tx_state_e  state;
  tsx_pkg::frame_hdr_t hdr;

  logic [addr_w-1:0]          rd_ptr;
  logic [hdr_cnt_w-1:0]       hdr_cnt;
  logic [ifg_w-1:0]           ifg_cnt;
  logic [16:0]                tx_cnt;
  logic [16:0]                frame_end;
  logic [7:0]                 low_byte;
  logic [2:0]                 ref_sel;
  logic [tsx_pkg::time_w-1:0] ref_time;
  logic [tsx_pkg::time_w-1:0] target;
  logic                       ifg_ok;
  logic                       launch;
  logic [15:0]                commit_ptr_w;
  logic [15:0]                rd_ptr_w;

  assign rd_addr = rd_ptr;
  assign ifg_ok  = (ifg_cnt == ifg_w'(ifg_cycles));

  // selector 0 means no offset
  assign ref_sel  = hdr.timestamp[62:60];
  assign ref_time = (ref_sel == 3'd0) ? '0 : local_times[ref_sel - 3'd1];
  assign target   = hdr.timestamp[tsx_pkg::time_w-1:0] + ref_time;

  // byte index of the first fcs byte
  assign frame_end = {1'b0, hdr.len} + 17'(tsx_pkg::preamble_len);

  // sync and immediate frames only wait for the gap
  always_comb begin
    launch = 1'b0;
    if (state == tsx_pkg::WAITING && ifg_ok) begin
      launch = hdr.timestamp[63] ||
               (hdr.timestamp[tsx_pkg::time_w-1:0] == '0) ||
               (global_counter[tsx_pkg::time_w-1:0] == target);
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state          <= tsx_pkg::IDLE;
      rd_ptr         <= '0;
      hdr_cnt        <= '0;
      ifg_cnt        <= ifg_w'(ifg_cycles);
      tx_cnt         <= '0;
      gmii           <= '0;
      crc_init       <= 1'b0;
      crc_en         <= 1'b0;
      local_time_req <= '0;
    end else begin
      gmii.tx_en     <= 1'b0;
      gmii.txd       <= 8'h00;
      crc_init       <= 1'b0;
      crc_en         <= 1'b0;
      local_time_req <= '0;

      if (!ifg_ok) begin
        ifg_cnt <= ifg_cnt + 1'b1;
      end

      case (state)
        tsx_pkg::IDLE: begin
          // a pointer gap means a whole frame is committed
          if (rd_ptr != commit_ptr) begin
            state   <= tsx_pkg::HDR_LOAD;
            hdr_cnt <= '0;
          end
        end
        tsx_pkg::HDR_LOAD: begin
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt < tsx_pkg::hdr_words) begin
            rd_ptr <= rd_ptr + 1'b1;
          end
          // read data trails the address by one cycle
          if (hdr_cnt != '0) begin
            hdr <= {hdr[hdr_bits-17:0], rd_q};
          end
          if (hdr_cnt == tsx_pkg::hdr_words) begin
            state <= tsx_pkg::WAITING;
          end
        end
        tsx_pkg::WAITING: begin
          // first preamble byte goes out on the launch edge
          if (launch) begin
            state      <= tsx_pkg::SENDING;
            tx_cnt     <= 17'd1;
            gmii.tx_en <= 1'b1;
            gmii.txd   <= 8'h55;
            if (hdr.timestamp[63] && ref_sel != 3'd0) begin
              local_time_req <= req_one << (ref_sel - 3'd1);
            end
          end
        end
        tsx_pkg::SENDING: begin
          tx_cnt     <= tx_cnt + 17'd1;
          gmii.tx_en <= 1'b1;
          if (tx_cnt < sfd_idx) begin
            gmii.txd <= 8'h55;
          end else if (tx_cnt == sfd_idx) begin
            gmii.txd <= 8'hd5;
            crc_init <= 1'b1;
          end else if (tx_cnt == frame_end) begin
            gmii.txd <= fcs[31:24];
            state    <= tsx_pkg::FCS_1;
          end else if (!tx_cnt[0]) begin
            // high byte now, keep the low byte and fetch the next word
            gmii.txd <= rd_q[15:8];
            low_byte <= rd_q[7:0];
            rd_ptr   <= rd_ptr + 1'b1;
            crc_en   <= 1'b1;
          end else begin
            gmii.txd <= low_byte;
            crc_en   <= 1'b1;
          end
        end
        tsx_pkg::FCS_1: begin
          state      <= tsx_pkg::FCS_2;
          gmii.tx_en <= 1'b1;
          gmii.txd   <= fcs[23:16];
        end
        tsx_pkg::FCS_2: begin
          state      <= tsx_pkg::FCS_3;
          gmii.tx_en <= 1'b1;
          gmii.txd   <= fcs[15:8];
        end
        tsx_pkg::FCS_3: begin
          // rd_ptr already sits on the next frame header
          state      <= tsx_pkg::IDLE;
          gmii.tx_en <= 1'b1;
          gmii.txd   <= fcs[7:0];
          ifg_cnt    <= '0;
        end
        default: begin
          state <= tsx_pkg::IDLE;
        end
      endcase
    end
  end

  assign commit_ptr_w = 16'(commit_ptr);
  assign rd_ptr_w     = 16'(rd_ptr);

  // leds are active low
  always_comb begin
    case (dipsw)
      tsx_pkg::VIEW_TS_0:      led = ~hdr.timestamp[7:0];
      tsx_pkg::VIEW_TS_1:      led = ~hdr.timestamp[15:8];
      tsx_pkg::VIEW_TS_2:      led = ~hdr.timestamp[23:16];
      tsx_pkg::VIEW_TS_3:      led = ~hdr.timestamp[31:24];
      tsx_pkg::VIEW_TS_4:      led = ~hdr.timestamp[39:32];
      tsx_pkg::VIEW_TS_5:      led = ~hdr.timestamp[47:40];
      tsx_pkg::VIEW_TS_6:      led = ~hdr.timestamp[55:48];
      tsx_pkg::VIEW_TS_7:      led = ~hdr.timestamp[63:56];
      tsx_pkg::VIEW_COMMIT_LO: led = ~commit_ptr_w[7:0];
      tsx_pkg::VIEW_COMMIT_HI: led = ~commit_ptr_w[15:8];
      tsx_pkg::VIEW_RD_LO:     led = ~rd_ptr_w[7:0];
      tsx_pkg::VIEW_RD_HI:     led = ~rd_ptr_w[15:8];
      tsx_pkg::VIEW_STATE:     led = ~{2'b00, gmii.tx_en, crc_init, crc_en, state};
      tsx_pkg::VIEW_IFG:       led = ~8'(ifg_cnt);
      tsx_pkg::VIEW_HDR_CNT:   led = ~8'(hdr_cnt);
      tsx_pkg::VIEW_TX_CNT_LO: led = ~tx_cnt[7:0];
      tsx_pkg::VIEW_TX_CNT_HI: led = ~tx_cnt[15:8];
      tsx_pkg::VIEW_LEN_LO:    led = ~hdr.len[7:0];
      tsx_pkg::VIEW_LEN_HI:    led = ~hdr.len[15:8];
      tsx_pkg::VIEW_HASH_0:    led = ~hdr.hash[7:0];
      tsx_pkg::VIEW_HASH_1:    led = ~hdr.hash[15:8];
      tsx_pkg::VIEW_HASH_2:    led = ~hdr.hash[23:16];
      tsx_pkg::VIEW_HASH_3:    led = ~hdr.hash[31:24];
      default:                 led = 8'hff;
    endcase
  end

  // a snapshot request is a single reference and comes only with a launch
  a_req_onehot: assert property (
    @(posedge gmii_tx_clk) disable iff (sys_rst)
    (|local_time_req) |-> $onehot(local_time_req) && $rose(gmii.tx_en)
  );

  // inter-frame gap seen on the bus
  a_ifg_kept: assert property (
    @(posedge gmii_tx_clk) disable iff (sys_rst)
    $fell(gmii.tx_en) |-> !gmii.tx_en [*ifg_cycles]
  );

  // reads stay inside committed frames
  a_rd_ptr_bound: assert property (
    @(posedge gmii_tx_clk) disable iff (sys_rst)
    (rd_ptr == commit_ptr) |=> $stable(rd_ptr)
  );

endmodule

// File: tb.f
+incdir+.
tsx_pkg.sv
eth_fcs_gen.sv
tx_slot_ring.sv
tx_timebase.sv
frame_sender.sv
timed_tx_top.sv
tb_timed_tx.sv

// File: tb_frame_table.svh
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// one line of the stimulus table
typedef struct packed {
  logic [15:0] len;
  logic        sync;
  logic [2:0]  sel;
  logic        timed;
  logic [15:0] delay;
} frame_entry_t;

// what the monitor expects of one burst
typedef struct packed {
  logic [15:0] len;
  logic [63:0] ts;
  logic [31:0] hash;
  logic        timed;
  logic [47:0] target;
  logic [6:0]  req;
} frame_exp_t;

localparam int n_frames = 12;

// columns: length in bytes, sync, selector, timed, launch delay in cycles after the write
localparam frame_entry_t frame_table [n_frames] = '{
  {16'd20, 1'b0, 3'd0, 1'b0, 16'd0},
  {16'd7,  1'b0, 3'd2, 1'b0, 16'd0},
  {16'd33, 1'b0, 3'd0, 1'b0, 16'd0},
  {16'd16, 1'b0, 3'd0, 1'b1, 16'd50},
  {16'd10, 1'b1, 3'd3, 1'b0, 16'd0},
  {16'd12, 1'b0, 3'd3, 1'b1, 16'd60},
  {16'd40, 1'b0, 3'd0, 1'b0, 16'd0},
  {16'd25, 1'b0, 3'd5, 1'b0, 16'd0},
  {16'd2,  1'b0, 3'd0, 1'b0, 16'd0},
  {16'd1,  1'b0, 3'd0, 1'b0, 16'd0},
  {16'd9,  1'b1, 3'd7, 1'b0, 16'd0},
  {16'd5,  1'b0, 3'd7, 1'b1, 16'd45}
};

// msb first register, each byte enters lsb first as on the wire
function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
  logic [31:0] c;
  logic        fb;
  c = crc;
  for (int i = 0; i < 8; i++) begin
    fb = c[31] ^ b[i];
    c  = {c[30:0], 1'b0} ^ (fb ? 32'h04c11db7 : 32'h0);
  end
  return c;
endfunction

// complemented and bit reversed, byte 0 is sent first
function automatic logic [31:0] fcs_wire(input logic [31:0] crc);
  logic [31:0] r;
  for (int i = 0; i < 32; i++) begin
    r[i] = ~crc[31 - i];
  end
  return r;
endfunction

// generous bound, every frame may wait for its delay and a full gap
function automatic int timeout_cycles();
  int sum;
  sum = 300;
  for (int i = 0; i < n_frames; i++) begin
    sum += frame_table[i].delay + 3 * frame_table[i].len + 60;
  end
  return sum;
endfunction

// preamble, sfd, payload high byte first, then the reference fcs
task automatic model_frame(input logic [15:0] len);
  logic [31:0] crc;
  logic [31:0] fcs;
  logic [7:0]  b;
  crc = 32'hffffffff;
  for (int i = 0; i < 7; i++) begin
    exp_bytes.push_back(8'h55);
  end
  exp_bytes.push_back(8'hd5);
  for (int i = 0; i < len; i++) begin
    b   = (i % 2 == 1) ? pay_words[i / 2][7:0] : pay_words[i / 2][15:8];
    crc = crc_step(crc, b);
    exp_bytes.push_back(b);
  end
  fcs = fcs_wire(crc);
  for (int i = 0; i < 4; i++) begin
    exp_bytes.push_back(fcs[8 * i +: 8]);
  end
endtask

`endif

// File: tb_timed_tx.sv
module tb_timed_tx;

  localparam int addr_w     = 6;
  localparam int ifg_cycles = 12;

  logic              gmii_tx_clk;
  logic              sys_rst;
  tsx_pkg::host_wr_t host_wr;
  logic              commit;
  logic [7:0]        dipsw;
  tsx_pkg::gmii_tx_t gmii;
  logic [63:0]       global_counter;
  logic [6:0]        local_time_req;
  logic [7:0]        led;

  logic [7:0]  exp_bytes [$];
  logic [15:0] pay_words [64];

  `include "tb_frame_table.svh"

  frame_exp_t  exp_frames [$];
  frame_exp_t  cur;
  logic [47:0] ref_model [8];
  logic [63:0] prev_gc;
  logic        prev_rst = 1'b1;
  logic        in_burst = 1'b0;
  int          burst_len = 0;
  int          gap = 0;
  int          done_cnt = 0;
  int          words_written = 0;
  int          words_done = 0;
  int          cycles = 0;
  int          limit;
  int          checks = 0;
  int          val_errs = 0;
  int          other_errs = 0;
  int          view_idx = 0;
  integer      seed;

  timed_tx_top #(
    .addr_w(addr_w),
    .ifg_cycles(ifg_cycles)
  ) i_dut (
    .gmii_tx_clk(gmii_tx_clk),
    .sys_rst(sys_rst),
    .host_wr(host_wr),
    .commit(commit),
    .dipsw(dipsw),
    .gmii(gmii),
    .global_counter(global_counter),
    .local_time_req(local_time_req),
    .led(led)
  );

  initial begin
    gmii_tx_clk = 1'b0;
    forever begin
      #5 gmii_tx_clk = ~gmii_tx_clk;
    end
  end

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      val_errs++;
      $display("ERR t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
  endtask

  // timestamp bytes, length, hash, then two codes no view uses
  function automatic logic [7:0] view_code(input int idx);
    if (idx < 8) begin
      return 8'(idx);
    end else if (idx < 10) begin
      return 8'h60 + 8'(idx - 8);
    end else if (idx < 14) begin
      return 8'h70 + 8'(idx - 10);
    end
    return (idx == 14) ? 8'h99 : 8'h12;
  endfunction

  function automatic logic [7:0] expected_led(input logic [7:0] code, input frame_exp_t f);
    logic [7:0] v;
    v = 8'h00;
    if (code < 8'h08) begin
      v = f.ts[8 * code +: 8];
    end else if (code == tsx_pkg::VIEW_LEN_LO || code == tsx_pkg::VIEW_LEN_HI) begin
      v = f.len[8 * code[0] +: 8];
    end else if (code >= tsx_pkg::VIEW_HASH_0 && code <= tsx_pkg::VIEW_HASH_3) begin
      v = f.hash[8 * code[1:0] +: 8];
    end
    // active low, so unknown codes leave all leds dark
    return ~v;
  endfunction

  task automatic send_word(input logic [15:0] w);
    @(posedge gmii_tx_clk);
    host_wr <= {1'b1, w};
  endtask

  task automatic write_frame(input int idx);
    frame_entry_t   e;
    frame_exp_t     f;
    int             n_words;
    logic [47:0]    t;
    logic [111:0]   hdr;
    e       = frame_table[idx];
    n_words = (e.len + 1) / 2;
    // timed frames are scheduled against an idle sender
    while (e.timed && done_cnt != idx) begin
      @(posedge gmii_tx_clk);
    end
    // keep the ring from filling up
    while (words_written - words_done + tsx_pkg::hdr_words + n_words > 60) begin
      @(posedge gmii_tx_clk);
    end
    for (int i = 0; i < n_words; i++) begin
      pay_words[i] = 16'($random(seed));
    end
    f.len    = e.len;
    f.hash   = $random(seed);
    f.timed  = e.timed;
    f.req    = e.sync ? (7'd1 << (e.sel - 3'd1)) : 7'd0;
    f.target = global_counter[47:0] + 48'(e.delay);
    if (e.timed) begin
      t = f.target - ref_model[e.sel];
    end else if (e.sync) begin
      t = 48'($random(seed));
    end else begin
      t = '0;
    end
    f.ts = {e.sync, e.sel, 12'($random(seed)), t};
    model_frame(e.len);
    exp_frames.push_back(f);
    hdr = {f.len, f.ts, f.hash};
    for (int i = 0; i < tsx_pkg::hdr_words; i++) begin
      send_word(hdr[111 - 16 * i -: 16]);
    end
    for (int i = 0; i < n_words; i++) begin
      send_word(pay_words[i]);
    end
    @(posedge gmii_tx_clk);
    host_wr <= '0;
    commit  <= 1'b1;
    @(posedge gmii_tx_clk);
    commit  <= 1'b0;
    words_written += tsx_pkg::hdr_words + n_words;
  endtask

  // walk the led views all the time
  always @(posedge gmii_tx_clk) begin
    view_idx <= (view_idx + 1) % 16;
    dipsw    <= view_code(view_idx);
  end

  // gmii monitor, samples on the falling edge
  always @(negedge gmii_tx_clk) begin
    if (!sys_rst && !prev_rst) begin
      check_equal("global_counter", prev_gc + 64'd1, global_counter);
    end
    if (gmii.tx_en && !in_burst) begin
      in_burst  = 1'b1;
      burst_len = 0;
      if (exp_frames.size() == 0) begin
        other_errs++;
        $display("burst on gmii at %0t with no committed frame left", $time);
        cur = '0;
      end else begin
        cur = exp_frames.pop_front();
      end
      if (done_cnt > 0 && gap < ifg_cycles) begin
        other_errs++;
        $display("gap of only %0d idle cycles before frame %0d at %0t", gap, done_cnt, $time);
      end
      // launch edge follows the cycle that matched the target
      if (cur.timed) begin
        check_equal("launch global_counter", 64'(cur.target), 64'(prev_gc[47:0]));
      end
      check_equal("local_time_req", 64'(cur.req), 64'(local_time_req));
      for (int k = 0; k < 7; k++) begin
        if (cur.req[k]) begin
          ref_model[k + 1] = global_counter[47:0];
        end
      end
    end else begin
      check_equal("local_time_req", 64'd0, 64'(local_time_req));
    end
    if (gmii.tx_en) begin
      burst_len++;
      if (exp_bytes.size() == 0) begin
        other_errs++;
        $display("more bytes on gmii than the model holds at %0t", $time);
      end else begin
        check_equal("gmii.txd", exp_bytes.pop_front(), gmii.txd);
      end
      check_equal("led", expected_led(dipsw, cur), led);
    end else if (in_burst) begin
      in_burst = 1'b0;
      check_equal("burst length", cur.len + 12, burst_len);
      words_done += tsx_pkg::hdr_words + (cur.len + 1) / 2;
      done_cnt++;
      gap = 1;
    end else begin
      gap++;
    end
    prev_gc  = global_counter;
    prev_rst = sys_rst;
  end

  always @(posedge gmii_tx_clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, %0d of %0d frames sent", cycles, done_cnt, n_frames);
      print_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed    = 32'hed286275;
    limit   = timeout_cycles();
    sys_rst = 1'b1;
    host_wr = '0;
    commit  = 1'b0;
    dipsw   = 8'h00;
    for (int k = 0; k < 8; k++) begin
      ref_model[k] = '0;
    end
    repeat (4) @(posedge gmii_tx_clk);
    sys_rst <= 1'b0;
    for (int i = 0; i < n_frames; i++) begin
      write_frame(i);
    end
    while (done_cnt != n_frames) begin
      @(posedge gmii_tx_clk);
    end
    // a stray burst after the last frame would show up here
    repeat (3 * ifg_cycles) @(posedge gmii_tx_clk);
    if (exp_bytes.size() != 0 || in_burst) begin
      other_errs++;
      $display("%0d expected bytes never appeared on gmii", exp_bytes.size());
    end
    print_counts();
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: timed_tx_top.sv
module timed_tx_top #(
  parameter int addr_w     = 14,
  parameter int ifg_cycles = 12
) (
  input  logic                              gmii_tx_clk,
  input  logic                              sys_rst,
  input  tsx_pkg::host_wr_t                 host_wr,
  input  logic                              commit,
  input  logic [7:0]                        dipsw,
  output tsx_pkg::gmii_tx_t                 gmii,
  output logic [63:0]                       global_counter,
  output logic [tsx_pkg::n_local_times-1:0] local_time_req,
  output logic [7:0]                        led
);

  logic [addr_w-1:0] rd_addr;
  logic [addr_w-1:0] commit_ptr;
  logic [15:0]       rd_q;
  logic [31:0]       fcs;
  logic              crc_init;
  logic              crc_en;
  logic [tsx_pkg::n_local_times-1:0][tsx_pkg::time_w-1:0] local_times;

  tx_slot_ring #(
    .addr_w(addr_w)
  ) i_ring (
    .gmii_tx_clk(gmii_tx_clk),
    .sys_rst(sys_rst),
    .host_wr(host_wr),
    .commit(commit),
    .rd_addr(rd_addr),
    .rd_q(rd_q),
    .commit_ptr(commit_ptr)
  );

  tx_timebase i_timebase (
    .gmii_tx_clk(gmii_tx_clk),
    .sys_rst(sys_rst),
    .local_time_req(local_time_req),
    .global_counter(global_counter),
    .local_times(local_times)
  );

  frame_sender #(
    .addr_w(addr_w),
    .ifg_cycles(ifg_cycles)
  ) i_sender (
    .gmii_tx_clk(gmii_tx_clk),
    .sys_rst(sys_rst),
    .commit_ptr(commit_ptr),
    .rd_q(rd_q),
    .rd_addr(rd_addr),
    .global_counter(global_counter),
    .local_times(local_times),
    .local_time_req(local_time_req),
    .fcs(fcs),
    .crc_init(crc_init),
    .crc_en(crc_en),
    .gmii(gmii),
    .dipsw(dipsw),
    .led(led)
  );

  // fed from the registered gmii byte
  eth_fcs_gen i_fcs (
    .gmii_tx_clk(gmii_tx_clk),
    .sys_rst(sys_rst),
    .crc_init(crc_init),
    .crc_en(crc_en),
    .data(gmii.txd),
    .fcs(fcs)
  );

endmodule

// File: tsx_pkg.sv
package tsx_pkg;

  // header layout in ring words
  localparam int hdr_words = 7;

  // seven bytes of 0x55 plus the SFD
  localparam int preamble_len = 8;

  // width of a scheduled launch time
  localparam int time_w = 48;

  // local time references selectable by bits 62:60
  localparam int n_local_times = 7;

  // one host word write
  typedef struct packed {
    logic        wr;
    logic [15:0] data;
  } host_wr_t;

  // gmii transmit byte lane
  typedef struct packed {
    logic [7:0] txd;
    logic       tx_en;
  } gmii_tx_t;

  // word 0 is len, words 1..4 the timestamp command, words 5..6 the hash
  typedef struct packed {
    logic [15:0] len;
    logic [63:0] timestamp;
    logic [31:0] hash;
  } frame_hdr_t;

  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    HDR_LOAD = 3'd1,
    WAITING  = 3'd2,
    SENDING  = 3'd3,
    FCS_1    = 3'd4,
    FCS_2    = 3'd5,
    FCS_3    = 3'd6
  } tx_state_e;

  // dip switch codes for the led debug view
  typedef enum logic [7:0] {
    VIEW_TS_0      = 8'h00,
    VIEW_TS_1      = 8'h01,
    VIEW_TS_2      = 8'h02,
    VIEW_TS_3      = 8'h03,
    VIEW_TS_4      = 8'h04,
    VIEW_TS_5      = 8'h05,
    VIEW_TS_6      = 8'h06,
    VIEW_TS_7      = 8'h07,
    VIEW_COMMIT_LO = 8'h10,
    VIEW_COMMIT_HI = 8'h11,
    VIEW_RD_LO     = 8'h14,
    VIEW_RD_HI     = 8'h15,
    VIEW_STATE     = 8'h20,
    VIEW_IFG       = 8'h30,
    VIEW_HDR_CNT   = 8'h40,
    VIEW_TX_CNT_LO = 8'h50,
    VIEW_TX_CNT_HI = 8'h51,
    VIEW_LEN_LO    = 8'h60,
    VIEW_LEN_HI    = 8'h61,
    VIEW_HASH_0    = 8'h70,
    VIEW_HASH_1    = 8'h71,
    VIEW_HASH_2    = 8'h72,
    VIEW_HASH_3    = 8'h73
  } led_view_e;

endpackage

// File: tx_slot_ring.sv
module tx_slot_ring #(
  parameter int addr_w = 14
) (
  input  logic                gmii_tx_clk,
  input  logic                sys_rst,
  input  tsx_pkg::host_wr_t   host_wr,
  input  logic                commit,
  input  logic [addr_w-1:0]   rd_addr,
  output logic [15:0]         rd_q,
  output logic [addr_w-1:0]   commit_ptr
);

  localparam int depth = 2 ** addr_w;

  logic [15:0]       mem [depth];
  logic [addr_w-1:0] wr_ptr;

  // host side pointers, both wrap at the ring depth
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
    end else begin
      if (host_wr.wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // publish everything written so far as whole frames
      if (commit) begin
        commit_ptr <= wr_ptr;
      end
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (host_wr.wr) begin
      mem[wr_ptr] <= host_wr.data;
    end
  end

  // one cycle read latency for the sender
  always_ff @(posedge gmii_tx_clk) begin
    rd_q <= mem[rd_addr];
  end

  // a commit in a write cycle would leave the last word out of the frame
  a_commit_not_with_write: assert property (
    @(posedge gmii_tx_clk) disable iff (sys_rst)
    commit |-> !host_wr.wr
  );

endmodule

// File: tx_timebase.sv
module tx_timebase (
  input  logic                                                   gmii_tx_clk,
  input  logic                                                   sys_rst,
  input  logic [tsx_pkg::n_local_times-1:0]                      local_time_req,
  output logic [63:0]                                            global_counter,
  output logic [tsx_pkg::n_local_times-1:0][tsx_pkg::time_w-1:0] local_times
);

  // free running, starts from zero out of reset
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      global_counter <= '0;
    end else begin
      global_counter <= global_counter + 64'd1;
    end
  end

  // snapshot of the counter in the request cycle,
  // visible to the sender one cycle later
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      local_times <= '0;
    end else begin
      for (int i = 0; i < tsx_pkg::n_local_times; i++) begin
        if (local_time_req[i]) begin
          local_times[i] <= global_counter[tsx_pkg::time_w-1:0];
        end
      end
    end
  end

endmodule
